// File: files.f
hw/hybrid_pkg.sv
hw/trig_lut.sv
hw/sample_distributor.sv
hw/switching_law.sv
hw/gate_driver.sv
hw/hybrid_top.sv
verif/hybrid_assertions.sv
verif/hybrid_tb.sv

// File: hw/gate_driver.sv
// per-phase dead-time fsm, turns each sigma bit into complementary high and low gate levels
`timescale 1ns/1ps
`default_nettype none

module gate_driver #(
   parameter int N_PHASES    = 4,
   parameter int DEAD_CYCLES = 3     // both-low cycles between gates, at least 1
) (
   input  wire logic                i_clock,
   input  wire logic                i_rst_n,
   input  wire logic [N_PHASES-1:0] i_sigma,
   output logic [N_PHASES-1:0]      o_gate_hi,
   output logic [N_PHASES-1:0]      o_gate_lo
);
   import hybrid_pkg::*;

   // counter counts DEAD_CYCLES-1 down to 0
   localparam int CNT_W = (DEAD_CYCLES > 1) ? $clog2(DEAD_CYCLES) : 1;
   localparam logic [CNT_W-1:0] DEAD_LOAD = CNT_W'(DEAD_CYCLES - 1);

   for (genvar p = 0; p < N_PHASES; p++) begin : g_phase

      gate_state_t      state;
      logic [CNT_W-1:0] dead_cnt;
      logic             sigma_seen;   // sigma as of the previous edge

      // --------------------------------------------------
      // dead-time fsm
      // --------------------------------------------------
      always_ff @(posedge i_clock or negedge i_rst_n) begin
         if (!i_rst_n) begin
            state      <= GATE_OFF;
            dead_cnt   <= '0;
            sigma_seen <= 1'b1;        // matches sigma after reset
         end else begin
            sigma_seen <= i_sigma[p];
            if (i_sigma[p] != sigma_seen) begin
               // any edge on sigma restarts the dead time, even mid-count
               state    <= GATE_DEAD;
               dead_cnt <= DEAD_LOAD;
            end else begin
               case (state)
                  GATE_OFF: begin
                     state    <= GATE_DEAD;   // first turn-on still gets dead time
                     dead_cnt <= DEAD_LOAD;
                  end
                  GATE_DEAD: begin
                     if (dead_cnt == '0) begin
                        state <= sigma_seen ? GATE_HIGH : GATE_LOW;
                     end else begin
                        dead_cnt <= dead_cnt - 1'b1;
                     end
                  end
                  default: begin
                     // HIGH or LOW, hold until sigma moves
                  end
               endcase
            end
         end
      end

      // decoded straight from the state, never both at once
      assign o_gate_hi[p] = (state == GATE_HIGH);
      assign o_gate_lo[p] = (state == GATE_LOW);

   end

endmodule

`default_nettype wire

// File: hw/hybrid_pkg.sv
// shared widths and gate-driver state type, imported by every rtl block of the hybrid controller
`default_nettype none

package hybrid_pkg;

   // --------------------------------------------------
   // data widths
   // --------------------------------------------------
   localparam int SAMPLE_W = 14;   // signed adc samples, vc and ic
   localparam int THETA_W  = 32;   // full turn = 2**THETA_W
   localparam int TRIG_W   = 16;   // signed q1.14, one = 16384

   // products of scaled states and trig terms land here
   // z ~ 21 bits, times q1.14 ~ 36 bits, sum of two ~ 37 bits
   localparam int ACC_W    = 48;   // plenty of headroom, no overflow

   // table addressing below the two quadrant bits
   localparam int LUT_BITS = 6;    // 64-entry quarter wave

   // --------------------------------------------------
   // gate driver fsm
   // --------------------------------------------------
   // OFF    only right after reset
   // DEAD   both gates low while the counter runs
   // HIGH   high-side switch on, sigma = 1
   // LOW    low-side switch on, sigma = 0
   typedef enum logic [1:0] {
      GATE_OFF  = 2'd0,
      GATE_DEAD = 2'd1,
      GATE_HIGH = 2'd2,
      GATE_LOW  = 2'd3
   } gate_state_t;

endpackage

`default_nettype wire

// File: hw/hybrid_top.sv
// multiphase hybrid converter controller, sample stream and angle in, sigma and gate levels out
`timescale 1ns/1ps
`default_nettype none

module hybrid_top #(
   parameter int N_PHASES    = 4,
   parameter int DEAD_CYCLES = 3,
   parameter int MU_Z1       = 110,
   parameter int MU_Z2       = 121,
   parameter int VG          = 240000
) (
   input  wire logic                                  i_clock,
   input  wire logic                                  i_rst_n,
   input  wire logic                                  i_sample_stb,
   input  wire logic [$clog2(N_PHASES):0]             i_sample_phase,
   input  wire logic signed [hybrid_pkg::SAMPLE_W-1:0] i_vc,
   input  wire logic signed [hybrid_pkg::SAMPLE_W-1:0] i_ic,
   input  wire logic [hybrid_pkg::THETA_W-1:0]        i_theta,
   output logic [N_PHASES-1:0]                        o_sigma,
   output logic [N_PHASES-1:0]                        o_gate_hi,
   output logic [N_PHASES-1:0]                        o_gate_lo
);
   import hybrid_pkg::*;

   logic [N_PHASES-1:0][SAMPLE_W-1:0] phase_vc;       // latest sample per phase
   logic [N_PHASES-1:0][SAMPLE_W-1:0] phase_ic;
   logic [N_PHASES-1:0]               phase_update;   // one-cycle pulse per phase
   logic signed [TRIG_W-1:0]          sin_q;          // shared by all phases
   logic signed [TRIG_W-1:0]          cos_q;

   // --------------------------------------------------
   // front end
   // --------------------------------------------------
   sample_distributor #(
      .N_PHASES(N_PHASES)
   ) u_dist (
      .i_clock        (i_clock),
      .i_rst_n        (i_rst_n),
      .i_sample_stb   (i_sample_stb),
      .i_sample_phase (i_sample_phase),
      .i_vc           (i_vc),
      .i_ic           (i_ic),
      .o_vc           (phase_vc),
      .o_ic           (phase_ic),
      .o_update       (phase_update)
   );

   trig_lut u_trig (
      .i_clock (i_clock),
      .i_rst_n (i_rst_n),
      .i_theta (i_theta),
      .o_sin   (sin_q),
      .o_cos   (cos_q)
   );

   // one switching law per phase
   for (genvar p = 0; p < N_PHASES; p++) begin : g_law
      switching_law #(
         .MU_Z1 (MU_Z1),
         .MU_Z2 (MU_Z2),
         .VG    (VG)
      ) u_law (
         .i_clock  (i_clock),
         .i_rst_n  (i_rst_n),
         .i_update (phase_update[p]),
         .i_vc     (phase_vc[p]),
         .i_ic     (phase_ic[p]),
         .i_sin    (sin_q),
         .i_cos    (cos_q),
         .o_sigma  (o_sigma[p])
      );
   end

   // --------------------------------------------------
   // gate stage
   // --------------------------------------------------
   gate_driver #(
      .N_PHASES    (N_PHASES),
      .DEAD_CYCLES (DEAD_CYCLES)
   ) u_gate (
      .i_clock   (i_clock),
      .i_rst_n   (i_rst_n),
      .i_sigma   (o_sigma),
      .o_gate_hi (o_gate_hi),
      .o_gate_lo (o_gate_lo)
   );

endmodule

`default_nettype wire

// File: hw/sample_distributor.sv
// steers each strobed adc sample into its phase slot and pulses that phase's update line
`timescale 1ns/1ps
`default_nettype none

module sample_distributor #(
   parameter int N_PHASES = 4
) (
   input  wire logic                                        i_clock,
   input  wire logic                                        i_rst_n,
   input  wire logic                                        i_sample_stb,   // one-cycle strobe
   input  wire logic [$clog2(N_PHASES):0]                   i_sample_phase, // one spare bit
   input  wire logic signed [hybrid_pkg::SAMPLE_W-1:0]      i_vc,
   input  wire logic signed [hybrid_pkg::SAMPLE_W-1:0]      i_ic,
   output logic [N_PHASES-1:0][hybrid_pkg::SAMPLE_W-1:0]    o_vc,           // slot per phase
   output logic [N_PHASES-1:0][hybrid_pkg::SAMPLE_W-1:0]    o_ic,
   output logic [N_PHASES-1:0]                              o_update        // one-hot pulse
);
   import hybrid_pkg::*;

   localparam int PHASE_W = $clog2(N_PHASES) + 1;

   logic [N_PHASES-1:0] hit;   // decoded strobe, empty for out-of-range index

   // index >= N_PHASES matches no slot, so the sample just falls away
   always_comb begin
      for (int k = 0; k < N_PHASES; k++) begin
         hit[k] = i_sample_stb && (i_sample_phase == PHASE_W'(k));
      end
   end

   // update pulse lines up with the freshly latched slot
   always_ff @(posedge i_clock or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_update <= '0;
      end else begin
         o_update <= hit;
      end
   end

   // sample slots, each keeps the latest value for its phase
   always_ff @(posedge i_clock) begin
      for (int k = 0; k < N_PHASES; k++) begin
         if (hit[k]) begin
            o_vc[k] <= SAMPLE_W'(i_vc);
            o_ic[k] <= SAMPLE_W'(i_ic);
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/switching_law.sv
// one phase of the hybrid switching law, toggles sigma when the rotated state sits in the jump set
`timescale 1ns/1ps
`default_nettype none

module switching_law #(
   parameter int MU_Z1 = 110,      // voltage scale
   parameter int MU_Z2 = 121,      // current scale, carries sqrt(L/C)
   parameter int VG    = 240000    // input voltage in z1 units
) (
   input  wire logic                                  i_clock,
   input  wire logic                                  i_rst_n,
   input  wire logic                                  i_update,  // new sample for this phase
   input  wire logic signed [hybrid_pkg::SAMPLE_W-1:0] i_vc,
   input  wire logic signed [hybrid_pkg::SAMPLE_W-1:0] i_ic,
   input  wire logic signed [hybrid_pkg::TRIG_W-1:0]   i_sin,     // q1.14
   input  wire logic signed [hybrid_pkg::TRIG_W-1:0]   i_cos,     // q1.14
   output logic                                       o_sigma
);
   import hybrid_pkg::*;

   localparam logic signed [ACC_W-1:0] K_Z1 = ACC_W'(MU_Z1);
   localparam logic signed [ACC_W-1:0] K_Z2 = ACC_W'(MU_Z2);
   localparam logic signed [ACC_W-1:0] K_VG = ACC_W'(VG);

   logic                    sigma_q;   // switching state, 1 = high side on
   logic signed [ACC_W-1:0] vc_ext;
   logic signed [ACC_W-1:0] ic_ext;
   logic signed [ACC_W-1:0] sin_ext;
   logic signed [ACC_W-1:0] cos_ext;
   logic signed [ACC_W-1:0] z1;
   logic signed [ACC_W-1:0] z2;
   logic signed [ACC_W-1:0] rot_1;     // z rotated, before the sign term
   logic signed [ACC_W-1:0] rot_2;
   logic signed [ACC_W-1:0] jump_1;
   logic signed [ACC_W-1:0] jump_2;
   logic                    in_jump;   // both jump terms negative

   // --------------------------------------------------
   // state transform
   // --------------------------------------------------
   assign vc_ext  = ACC_W'(i_vc);     // sign extend everything up front
   assign ic_ext  = ACC_W'(i_ic);
   assign sin_ext = ACC_W'(i_sin);
   assign cos_ext = ACC_W'(i_cos);

   // s = -1 for sigma 1, +1 for sigma 0
   assign z1 = K_Z1 * vc_ext + (sigma_q ? -K_VG : K_VG);
   assign z2 = K_Z2 * ic_ext;

   // --------------------------------------------------
   // jump set, one quarter of the plane
   // --------------------------------------------------
   assign rot_1 = z1 * sin_ext + z2 * cos_ext;
   assign rot_2 = z2 * sin_ext - z1 * cos_ext;

   assign jump_1 = sigma_q ? -rot_1 : rot_1;   // times s
   assign jump_2 = sigma_q ? -rot_2 : rot_2;

   assign in_jump = jump_1[ACC_W-1] & jump_2[ACC_W-1];   // sign bits only

   // sigma only moves when a sample for this phase arrives
   always_ff @(posedge i_clock or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sigma_q <= 1'b1;                 // start on the high side
      end else if (i_update && in_jump) begin
         sigma_q <= ~sigma_q;
      end
   end

   assign o_sigma = sigma_q;

endmodule

`default_nettype wire

// File: hw/trig_lut.sv
// registered sine/cosine of a 32-bit angle from one quarter-wave table, shared by all phases
`timescale 1ns/1ps
`default_nettype none

module trig_lut (
   input  wire logic                                i_clock,
   input  wire logic                                i_rst_n,
   input  wire logic [hybrid_pkg::THETA_W-1:0]      i_theta,   // full turn = 2**THETA_W
   output logic signed [hybrid_pkg::TRIG_W-1:0]     o_sin,     // q1.14
   output logic signed [hybrid_pkg::TRIG_W-1:0]     o_cos      // q1.14
);
   import hybrid_pkg::*;

   localparam logic [TRIG_W-2:0] TRIG_ONE = 15'd16384;   // 1.0 in q1.14

   // round(16384 * sin(k * pi / 128)), k = 0..63
   localparam logic [TRIG_W-2:0] SINE_TAB [2**LUT_BITS] = '{
        0,   402,   804,  1205,  1606,  2006,  2404,  2801,
     3196,  3590,  3981,  4370,  4756,  5139,  5520,  5897,
     6270,  6639,  7005,  7366,  7723,  8076,  8423,  8765,
     9102,  9434,  9760, 10080, 10394, 10702, 11003, 11297,
    11585, 11866, 12140, 12406, 12665, 12916, 13160, 13395,
    13623, 13842, 14053, 14256, 14449, 14635, 14811, 14978,
    15137, 15286, 15426, 15557, 15679, 15791, 15893, 15986,
    16069, 16143, 16207, 16261, 16305, 16340, 16364, 16379
   };

   logic [1:0]               quadrant;     // top two angle bits
   logic [LUT_BITS-1:0]      idx;          // position inside the quadrant
   logic [LUT_BITS-1:0]      idx_mirror;   // 64 - idx, wraps to 0 at idx 0
   logic [TRIG_W-2:0]        mag_s;        // |sin| of the in-quadrant angle
   logic [TRIG_W-2:0]        mag_c;        // |cos| of the in-quadrant angle
   logic signed [TRIG_W-1:0] pos_s;
   logic signed [TRIG_W-1:0] pos_c;
   logic signed [TRIG_W-1:0] sin_d;
   logic signed [TRIG_W-1:0] cos_d;

   assign quadrant   = i_theta[THETA_W-1 -: 2];
   assign idx        = i_theta[THETA_W-3 -: LUT_BITS];
   assign idx_mirror = ~idx + 1'b1;

   assign mag_s = SINE_TAB[idx];
   // cos(a) = sin(90 - a), entry 64 is not in the table so 1.0 is patched in
   assign mag_c = (idx == '0) ? TRIG_ONE : SINE_TAB[idx_mirror];

   assign pos_s = {1'b0, mag_s};
   assign pos_c = {1'b0, mag_c};

   // --------------------------------------------------
   // quadrant fold
   // --------------------------------------------------
   always_comb begin
      case (quadrant)
         2'd0: begin            // 0..90
            sin_d = pos_s;
            cos_d = pos_c;
         end
         2'd1: begin            // 90..180
            sin_d = pos_c;
            cos_d = -pos_s;
         end
         2'd2: begin            // 180..270
            sin_d = -pos_s;
            cos_d = -pos_c;
         end
         default: begin         // 270..360
            sin_d = -pos_c;
            cos_d = pos_s;
         end
      endcase
   end

   always_ff @(posedge i_clock or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_sin <= '0;                  // angle 0 after reset
         o_cos <= {1'b0, TRIG_ONE};
      end else begin
         o_sin <= sin_d;
         o_cos <= cos_d;
      end
   end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module hybrid_tb -o hybrid_sim \
   && ./obj_dir/hybrid_sim | tee /dev/stderr | grep -q "TEST OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: verif/hybrid_assertions.sv
// concurrent gate checks, bound into gate_driver to watch every phase of the dead-time fsm
`timescale 1ns/1ps
`default_nettype none

module hybrid_assertions #(
   parameter int N_PHASES    = 4,
   parameter int DEAD_CYCLES = 3
) (
   input wire logic                i_clock,
   input wire logic                i_rst_n,
   input wire logic [N_PHASES-1:0] i_sigma,
   input wire logic [N_PHASES-1:0] o_gate_hi,
   input wire logic [N_PHASES-1:0] o_gate_lo
);

   for (genvar p = 0; p < N_PHASES; p++) begin : g_phase
      // shoot-through guard
      a_no_overlap: assert property (@(posedge i_clock) disable iff (!i_rst_n)
         !(o_gate_hi[p] && o_gate_lo[p]))
         else $error("phase %0d high and low gates on together", p);

      // sigma moved d cycles back, so both gates must still be off
      for (genvar d = 1; d <= DEAD_CYCLES; d++) begin : g_dead
         a_dead_low: assert property (@(posedge i_clock) disable iff (!i_rst_n)
            ($past(i_sigma[p], d) != $past(i_sigma[p], d + 1))
               |-> (!o_gate_hi[p] && !o_gate_lo[p]))
            else $error("phase %0d gate on %0d cycles after a sigma change", p, d);
      end
   end

endmodule

bind gate_driver hybrid_assertions #(
   .N_PHASES    (N_PHASES),
   .DEAD_CYCLES (DEAD_CYCLES)
) u_gate_sva (
   .i_clock   (i_clock),
   .i_rst_n   (i_rst_n),
   .i_sigma   (i_sigma),
   .o_gate_hi (o_gate_hi),
   .o_gate_lo (o_gate_lo)
);

`default_nettype wire

// File: verif/hybrid_tb.sv
// self-checking testbench that runs as the simulation top and drives hybrid_top as uut
`timescale 1ns/1ps
`default_nettype none

module hybrid_tb;
   import hybrid_pkg::*;

   localparam int N_PHASES    = 4;
   localparam int DEAD_CYCLES = 3;
   localparam int MU_Z1       = 110;
   localparam int MU_Z2       = 121;
   localparam int VG          = 240000;
   localparam int PHASE_W     = $clog2(N_PHASES) + 1;
   localparam int N_RAND      = 40;   // random samples per angle
   localparam int N_B2B       = 16;   // strobes in the burst

   // cycles each test takes and the watchdog allows twice the sum
   localparam int TEST_CYCLES = (3 + DEAD_CYCLES + 2)   // reset
      + 4 * (2 * N_RAND + 1)                            // four angles
      + 2 * 2 * N_PHASES + 1                            // isolation
      + 2 * N_PHASES * (DEAD_CYCLES + 3)                // dead time
      + (N_B2B + 3);                                    // burst
   localparam int MAX_CYCLES = 2 * TEST_CYCLES;

   logic                       i_clock;
   logic                       i_rst_n;
   logic                       i_sample_stb;
   logic [PHASE_W-1:0]         i_sample_phase;
   logic signed [SAMPLE_W-1:0] i_vc;
   logic signed [SAMPLE_W-1:0] i_ic;
   logic [THETA_W-1:0]         i_theta;
   logic [N_PHASES-1:0]        o_sigma;
   logic [N_PHASES-1:0]        o_gate_hi;
   logic [N_PHASES-1:0]        o_gate_lo;

   logic [N_PHASES-1:0] model_sigma;      // expected sigma per phase
   longint              model_sin;        // exact q1.14 at the test angles
   longint              model_cos;
   integer              seed = 32'hbfb8;
   int                  cycles = 0;
   int                  test_errors = 0;  // errors in the running test
   int                  tests_passed = 0;
   int                  tests_failed = 0;

   hybrid_top #(
      .N_PHASES    (N_PHASES),
      .DEAD_CYCLES (DEAD_CYCLES),
      .MU_Z1       (MU_Z1),
      .MU_Z2       (MU_Z2),
      .VG          (VG)
   ) uut (
      .i_clock        (i_clock),
      .i_rst_n        (i_rst_n),
      .i_sample_stb   (i_sample_stb),
      .i_sample_phase (i_sample_phase),
      .i_vc           (i_vc),
      .i_ic           (i_ic),
      .i_theta        (i_theta),
      .o_sigma        (o_sigma),
      .o_gate_hi      (o_gate_hi),
      .o_gate_lo      (o_gate_lo)
   );

   initial begin
      i_clock = 1'b0;
      forever #50 i_clock = ~i_clock;   // 100 ns period
   end

   // watchdog
   always @(posedge i_clock) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("run stopped, no finish after %0d cycles", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   // s = -1 on the high side and a jump needs both rotated terms negative
   function automatic logic next_sigma(input logic sig, input longint vc, input longint ic);
      longint s;
      longint z1;
      longint z2;
      longint j1;
      longint j2;
      s  = sig ? longint'(-1) : longint'(1);
      z1 = longint'(MU_Z1) * vc + s * longint'(VG);
      z2 = longint'(MU_Z2) * ic;
      j1 = s * (z1 * model_sin + z2 * model_cos);
      j2 = s * (z2 * model_sin - z1 * model_cos);
      return (j1 < 0 && j2 < 0) ? ~sig : sig;
   endfunction

   task automatic apply_model(input int ph, input logic signed [SAMPLE_W-1:0] vc,
                              input logic signed [SAMPLE_W-1:0] ic);
      if (ph < N_PHASES) begin          // out of range leaves every phase alone
         model_sigma[ph] = next_sigma(model_sigma[ph], longint'(vc), longint'(ic));
      end
   endtask

   task automatic check_sigma(input string name);
      assert (o_sigma == model_sigma) else begin
         $display("FAILED %s expected %b actual %b", name, model_sigma, o_sigma);
         test_errors++;
      end
   endtask

   task automatic check_gates(input string name, input logic [N_PHASES-1:0] exp_hi,
                              input logic [N_PHASES-1:0] exp_lo);
      assert (o_gate_hi == exp_hi && o_gate_lo == exp_lo) else begin
         $display("FAILED %s expected hi %b lo %b actual hi %b lo %b",
                  name, exp_hi, exp_lo, o_gate_hi, o_gate_lo);
         test_errors++;
      end
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   // called on a falling edge and sigma settles two falling edges later
   task automatic apply_sample(input string name, input int ph,
                               input logic signed [SAMPLE_W-1:0] vc,
                               input logic signed [SAMPLE_W-1:0] ic);
      i_sample_stb   = 1'b1;
      i_sample_phase = PHASE_W'(ph);
      i_vc           = vc;
      i_ic           = ic;
      @(negedge i_clock);
      i_sample_stb = 1'b0;
      @(negedge i_clock);
      apply_model(ph, vc, ic);
      check_sigma(name);
   endtask

   // the angle is exactly q * 90 degrees
   task automatic set_angle(input int q);
      i_theta = {q[1:0], {(THETA_W-2){1'b0}}};
      case (q)
         0: begin
            model_sin = 0;
            model_cos = 16384;
         end
         1: begin
            model_sin = 16384;
            model_cos = 0;
         end
         2: begin
            model_sin = 0;
            model_cos = -16384;
         end
         default: begin
            model_sin = -16384;
            model_cos = 0;
         end
      endcase
      @(negedge i_clock);   // lookup register catches up
   endtask

   task automatic random_samples(input string name);
      logic [31:0] rnd_v;
      logic [31:0] rnd_i;
      for (int i = 0; i < N_RAND; i++) begin
         rnd_v = $random(seed);
         rnd_i = $random(seed);
         apply_sample(name, int'(rnd_i[31:16] % N_PHASES), rnd_v[13:0], rnd_i[13:0]);
      end
   endtask

   // both gates low for the dead time and then the gate that matches sigma
   task automatic check_dead_time(input int p);
      logic exp_hi;
      logic exp_lo;
      for (int d = 1; d <= DEAD_CYCLES + 1; d++) begin
         @(negedge i_clock);
         exp_hi = (d > DEAD_CYCLES) && model_sigma[p];
         exp_lo = (d > DEAD_CYCLES) && !model_sigma[p];
         assert (o_gate_hi[p] == exp_hi && o_gate_lo[p] == exp_lo) else begin
            $display("FAILED dead_time phase %0d cycle %0d expected hi %b lo %b actual hi %b lo %b",
                     p, d, exp_hi, exp_lo, o_gate_hi[p], o_gate_lo[p]);
            test_errors++;
         end
      end
   endtask

   // one strobe per cycle with each checked two cycles after it
   task automatic back_to_back();
      logic [31:0]                rnd;
      int                         ph_q [N_B2B];
      logic signed [SAMPLE_W-1:0] vc_q [N_B2B];
      logic signed [SAMPLE_W-1:0] ic_q [N_B2B];
      for (int i = 0; i < N_B2B + 2; i++) begin
         if (i < N_B2B) begin
            rnd     = $random(seed);
            ph_q[i] = i % N_PHASES;
            vc_q[i] = rnd[13:0];
            ic_q[i] = rnd[29:16];
            i_sample_stb   = 1'b1;
            i_sample_phase = PHASE_W'(ph_q[i]);
            i_vc           = vc_q[i];
            i_ic           = ic_q[i];
         end else begin
            i_sample_stb = 1'b0;
         end
         if (i >= 2) begin
            apply_model(ph_q[i-2], vc_q[i-2], ic_q[i-2]);
            check_sigma("back_to_back");
         end
         @(negedge i_clock);
      end
   endtask

   task automatic close_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("%s: pass", name);
      end else begin
         tests_failed++;
         $display("%s: fail, %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      logic signed [SAMPLE_W-1:0] ic_t;   // sample that toggles at angle 0
      i_rst_n        = 1'b0;
      i_sample_stb   = 1'b0;
      i_sample_phase = '0;
      i_vc           = '0;
      i_ic           = '0;
      i_theta        = '0;
      model_sigma    = '1;
      model_sin      = 0;
      model_cos      = 16384;
      repeat (3) @(negedge i_clock);
      i_rst_n = 1'b1;

      check_sigma("reset_state");
      check_gates("reset_state", '0, '0);
      repeat (DEAD_CYCLES) @(negedge i_clock);
      check_gates("reset_state", '0, '0);     // still in dead time
      @(negedge i_clock);
      check_gates("reset_state", '1, '0);
      close_test("reset_state");

      for (int q = 0; q < 4; q++) begin      // 0, 90, 180, 270 degrees
         set_angle(q);
         random_samples($sformatf("angle_%0d", 90 * q));
         close_test($sformatf("angle_%0d", 90 * q));
      end

      // misrouted samples would flip the phase below the index
      set_angle(0);
      for (int k = 0; k < 2 * N_PHASES; k++) begin
         ic_t = model_sigma[k % N_PHASES] ? 14'sd100 : -14'sd100;
         apply_sample("phase_isolation", k, '0, ic_t);
      end
      close_test("phase_isolation");

      // two passes so every phase toggles toward both gates
      for (int k = 0; k < 2 * N_PHASES; k++) begin
         ic_t = model_sigma[k % N_PHASES] ? 14'sd100 : -14'sd100;
         apply_sample("dead_time", k % N_PHASES, '0, ic_t);
         check_dead_time(k % N_PHASES);
      end
      close_test("dead_time");

      set_angle(2);
      back_to_back();
      close_test("back_to_back");

      $display("%0d tests passed, %0d failed", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
